/* fcpu_pkg.sv */
package fcpu_pkg;

   ////////////////////
   // Widths
   localparam int DATA_W   = 16;
   localparam int RSV_ID_W = 4;
   localparam int INSTR_W  = 4;
   localparam int CDB_W    = RSV_ID_W + DATA_W; // Tag on top, value below

   typedef logic [DATA_W-1:0]   data_t;
   typedef logic [RSV_ID_W-1:0] rob_id_t;
   typedef logic [INSTR_W-1:0]  opcode_t;
   typedef logic [CDB_W-1:0]    cdb_t;

   ////////////////////
   // Opcodes
   localparam opcode_t I_LOAD   = 4'h1;
   localparam opcode_t I_LOADB  = 4'h2; // base - offset
   localparam opcode_t I_STORE  = 4'h3;
   localparam opcode_t I_STOREB = 4'h4; // base - offset

   ////////////////////
   // Sizes
   localparam int RS_DEPTH   = 4;
   localparam int SB_DEPTH   = 4;
   localparam int DMEM_WORDS = 64;
   localparam int RS_IDX_W   = $clog2(RS_DEPTH);
   localparam int SB_IDX_W   = $clog2(SB_DEPTH);
   localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

   // Queues inside the memory unit
   localparam int AQ_DEPTH_W = 2;
   localparam int AQ_ENTRY_W = INSTR_W + RSV_ID_W + DATA_W;
   localparam int LQ_DEPTH_W = 2;
   localparam int LQ_ENTRY_W = RSV_ID_W + DATA_W + 1 + DATA_W;

   function automatic logic is_store(opcode_t op);
      return (op == I_STORE) || (op == I_STOREB);
   endfunction

endpackage

/* fifo.sv */
`timescale 1ns/1ps

module fifo #(
   parameter int DEPTH_W = 2,
   parameter int WIDTH   = 8
) (
   input  logic             clk,
   input  logic             nrst,
   input  logic [WIDTH-1:0] i_data,
   input  logic             i_valid,
   output logic             o_ready,
   output logic [WIDTH-1:0] o_data,
   output logic             o_valid,
   input  logic             i_ready
);

   localparam int DEPTH = 2 ** DEPTH_W;

   logic [WIDTH-1:0]   mem [DEPTH];
   logic [DEPTH_W-1:0] head;
   logic [DEPTH_W-1:0] tail;
   logic [DEPTH_W:0]   count;
   logic               push;
   logic               pop;

   assign o_ready = (count != (DEPTH_W+1)'(DEPTH));
   assign o_valid = (count != '0);
   assign o_data  = mem[head];
   assign push    = i_valid && o_ready;
   assign pop     = o_valid && i_ready;

   always_ff @(posedge clk) begin
      if (nrst) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         if (push) begin
            tail <= tail + 1'b1;
         end
         if (pop) begin
            head <= head + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[tail] <= i_data;
      end
   end

endmodule

/* reservation_station.sv */
`timescale 1ns/1ps

module reservation_station (
   input  logic              clk,
   input  logic              nrst,
   input  fcpu_pkg::opcode_t i_opcode,
   input  fcpu_pkg::rob_id_t i_rob_id,
   input  fcpu_pkg::data_t   i_base,
   input  fcpu_pkg::rob_id_t i_base_tag,
   input  logic              i_base_filled,
   input  fcpu_pkg::data_t   i_offset,
   input  fcpu_pkg::rob_id_t i_offset_tag,
   input  logic              i_offset_filled,
   input  logic              i_alloc,
   output logic              o_full,
   input  fcpu_pkg::cdb_t    i_cdb,
   input  logic              i_cdb_valid,
   output logic              o_valid,
   output fcpu_pkg::opcode_t o_opcode,
   output fcpu_pkg::rob_id_t o_rob_id,
   output fcpu_pkg::data_t   o_base,
   output fcpu_pkg::data_t   o_offset,
   input  logic              i_ready
);
   import fcpu_pkg::*;

   opcode_t             opcode     [RS_DEPTH];
   rob_id_t             rob_id     [RS_DEPTH];
   data_t               base       [RS_DEPTH];
   rob_id_t             base_tag   [RS_DEPTH];
   data_t               offset     [RS_DEPTH];
   rob_id_t             offset_tag [RS_DEPTH];
   logic [RS_DEPTH-1:0] base_rdy;
   logic [RS_DEPTH-1:0] offset_rdy;
   logic [RS_IDX_W-1:0] head;
   logic [RS_IDX_W-1:0] tail;
   logic [RS_IDX_W:0]   count;
   rob_id_t             cdb_tag;
   data_t               cdb_val;
   logic                base_hit;
   logic                offset_hit;
   logic                issue;

   assign cdb_tag    = i_cdb[DATA_W +: RSV_ID_W];
   assign cdb_val    = i_cdb[DATA_W-1:0];
   assign base_hit   = i_cdb_valid && !i_base_filled && (i_base_tag == cdb_tag);
   assign offset_hit = i_cdb_valid && !i_offset_filled && (i_offset_tag == cdb_tag);

   // Only the oldest may issue, so addresses come out in program order
   assign o_full   = (count == (RS_IDX_W+1)'(RS_DEPTH));
   assign o_valid  = (count != '0) && base_rdy[head] && offset_rdy[head];
   assign o_opcode = opcode[head];
   assign o_rob_id = rob_id[head];
   assign o_base   = base[head];
   assign o_offset = offset[head];
   assign issue    = o_valid && i_ready;

   always_ff @(posedge clk) begin
      if (nrst) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         if (i_alloc) begin
            tail <= tail + 1'b1;
         end
         if (issue) begin
            head <= head + 1'b1;
         end
         if (i_alloc && !issue) begin
            count <= count + 1'b1;
         end else if (!i_alloc && issue) begin
            count <= count - 1'b1;
         end
      end
   end

   ////////////////////
   // Operand capture
   always_ff @(posedge clk) begin
      for (int i = 0; i < RS_DEPTH; i++) begin
         if (i_cdb_valid && !base_rdy[i] && (base_tag[i] == cdb_tag)) begin
            base[i]     <= cdb_val;
            base_rdy[i] <= 1'b1;
         end
         if (i_cdb_valid && !offset_rdy[i] && (offset_tag[i] == cdb_tag)) begin
            offset[i]     <= cdb_val;
            offset_rdy[i] <= 1'b1;
         end
      end
      if (i_alloc) begin
         opcode[tail]     <= i_opcode;
         rob_id[tail]     <= i_rob_id;
         base_tag[tail]   <= i_base_tag;
         offset_tag[tail] <= i_offset_tag;
         base[tail]       <= base_hit ? cdb_val : i_base;   // Broadcast on arrival
         base_rdy[tail]   <= i_base_filled || base_hit;
         offset[tail]     <= offset_hit ? cdb_val : i_offset;
         offset_rdy[tail] <= i_offset_filled || offset_hit;
      end
   end

endmodule

/* store_buffer.sv */
`timescale 1ns/1ps

module store_buffer (
   input  logic              clk,
   input  logic              nrst,
   input  logic              i_push,
   input  fcpu_pkg::rob_id_t i_rob_id,
   input  fcpu_pkg::data_t   i_data,
   input  fcpu_pkg::rob_id_t i_data_tag,
   input  logic              i_data_filled,
   output logic              o_full,
   input  fcpu_pkg::cdb_t    i_cdb,
   input  logic              i_cdb_valid,
   input  logic              i_addr_valid,
   input  fcpu_pkg::rob_id_t i_addr_rob_id,
   input  fcpu_pkg::data_t   i_addr,
   input  logic              i_commit_valid,
   input  fcpu_pkg::rob_id_t i_commit_id,
   input  logic              i_commit_invalidate,
   input  fcpu_pkg::data_t   i_lookup_addr,
   output logic              o_match,
   output logic              o_match_data_ready,
   output fcpu_pkg::data_t   o_match_data,
   output logic              o_head_valid,
   output logic              o_head_write,
   output fcpu_pkg::data_t   o_head_addr,
   output fcpu_pkg::data_t   o_head_data,
   input  logic              i_pop
);
   import fcpu_pkg::*;

   logic [SB_DEPTH-1:0] valid;
   rob_id_t             rob_id   [SB_DEPTH];
   data_t               data     [SB_DEPTH];
   rob_id_t             data_tag [SB_DEPTH];
   data_t               addr     [SB_DEPTH];
   logic [SB_DEPTH-1:0] data_rdy;
   logic [SB_DEPTH-1:0] addr_rdy;
   logic [SB_DEPTH-1:0] committed;
   logic [SB_DEPTH-1:0] inval;
   logic [SB_IDX_W-1:0] head;
   logic [SB_IDX_W-1:0] tail;
   rob_id_t             cdb_tag;
   logic                data_hit;
   logic                drop;
   logic                retire;

   assign cdb_tag  = i_cdb[DATA_W +: RSV_ID_W];
   assign data_hit = i_cdb_valid && !i_data_filled && (i_data_tag == cdb_tag);

   assign o_full       = valid[tail];
   assign o_head_valid = valid[head] && data_rdy[head] && addr_rdy[head];
   assign o_head_write = valid[head] && committed[head] && !inval[head];
   assign o_head_addr  = addr[head];
   assign o_head_data  = data[head];

   // Invalidated head leaves without a memory write
   assign drop   = valid[head] && committed[head] && inval[head];
   assign retire = i_pop || drop;

   always_ff @(posedge clk) begin
      if (nrst) begin
         valid <= '0;
         head  <= '0;
         tail  <= '0;
      end else begin
         if (i_push) begin
            valid[tail] <= 1'b1;
            tail        <= tail + 1'b1;
         end
         if (retire) begin
            valid[head] <= 1'b0;
            head        <= head + 1'b1;
         end
      end
   end

   ////////////////////
   // Entry updates
   always_ff @(posedge clk) begin
      for (int i = 0; i < SB_DEPTH; i++) begin
         if (valid[i] && i_cdb_valid && !data_rdy[i] && (data_tag[i] == cdb_tag)) begin
            data[i]     <= i_cdb[DATA_W-1:0];
            data_rdy[i] <= 1'b1;
         end
         if (valid[i] && i_addr_valid && (rob_id[i] == i_addr_rob_id)) begin
            addr[i]     <= i_addr;
            addr_rdy[i] <= 1'b1;
         end
         if (valid[i] && i_commit_valid && (rob_id[i] == i_commit_id)) begin
            committed[i] <= 1'b1;
            inval[i]     <= i_commit_invalidate;
         end
      end
      if (i_push) begin
         rob_id[tail]    <= i_rob_id;
         data_tag[tail]  <= i_data_tag;
         data[tail]      <= data_hit ? i_cdb[DATA_W-1:0] : i_data;
         data_rdy[tail]  <= i_data_filled || data_hit;
         addr_rdy[tail]  <= 1'b0;
         committed[tail] <= 1'b0;
         inval[tail]     <= 1'b0;
      end
   end

   // Walk oldest to youngest so the last hit is the youngest store
   always_comb begin
      logic [SB_IDX_W-1:0] idx;
      o_match            = 1'b0;
      o_match_data_ready = 1'b0;
      o_match_data       = '0;
      for (int k = 0; k < SB_DEPTH; k++) begin
         idx = head + SB_IDX_W'(k);
         if (valid[idx] && addr_rdy[idx] && !inval[idx] && (addr[idx] == i_lookup_addr)) begin
            o_match            = 1'b1;
            o_match_data_ready = data_rdy[idx];
            o_match_data       = data[idx];
         end
      end
   end

endmodule

/* memory_functional_unit.sv */
`timescale 1ns/1ps

module memory_functional_unit (
   input  logic              clk,
   input  logic              nrst,
   input  logic              i_valid,
   output logic              o_ready,
   input  fcpu_pkg::opcode_t i_opcode,
   input  fcpu_pkg::rob_id_t i_rob_id,
   input  fcpu_pkg::data_t   i_base,
   input  fcpu_pkg::rob_id_t i_base_tag,
   input  logic              i_base_filled,
   input  fcpu_pkg::data_t   i_offset,
   input  fcpu_pkg::rob_id_t i_offset_tag,
   input  logic              i_offset_filled,
   input  fcpu_pkg::data_t   i_data,
   input  fcpu_pkg::rob_id_t i_data_tag,
   input  logic              i_data_filled,
   input  fcpu_pkg::cdb_t    i_cdb,
   input  logic              i_cdb_valid,
   input  logic              i_commit_valid,
   input  fcpu_pkg::rob_id_t i_commit_id,
   input  logic              i_commit_invalidate,
   output logic              o_fwd_valid,
   output fcpu_pkg::cdb_t    o_fwd_cdb,
   input  logic              i_fwd_ready,
   output logic              o_mem_valid,
   output logic              o_mem_write,
   output fcpu_pkg::data_t   o_mem_addr,
   output fcpu_pkg::data_t   o_mem_data,
   output fcpu_pkg::rob_id_t o_mem_rob_id,
   input  logic              i_mem_ready
);
   import fcpu_pkg::*;

   logic    rs_full;
   logic    sb_full;
   logic    alloc;
   logic    rs_valid;
   logic    rs_ready;
   opcode_t rs_opcode;
   rob_id_t rs_rob_id;
   data_t   rs_base;
   data_t   rs_offset;
   data_t   rs_addr;
   logic    aq_valid;
   logic    aq_ready;
   logic    aq_store;
   opcode_t aq_opcode;
   rob_id_t aq_rob_id;
   data_t   aq_addr;
   logic    sb_match;
   logic    sb_match_data_ready;
   data_t   sb_match_data;
   logic    load_wait;
   logic    sb_head_valid;
   logic    sb_head_write;
   data_t   sb_head_addr;
   data_t   sb_head_data;
   logic    sb_pop;
   logic    store_req;
   logic    lq_in_valid;
   logic    lq_in_ready;
   logic    lq_valid;
   logic    lq_ready;
   logic    lq_fwd;
   logic    lq_read;
   rob_id_t lq_rob_id;
   data_t   lq_addr;
   data_t   lq_data;

   // A store also needs a store buffer slot
   assign o_ready = !rs_full && !(is_store(i_opcode) && sb_full);
   assign alloc   = i_valid && o_ready;

   reservation_station rs_inst (
      .clk             (clk),
      .nrst            (nrst),
      .i_opcode        (i_opcode),
      .i_rob_id        (i_rob_id),
      .i_base          (i_base),
      .i_base_tag      (i_base_tag),
      .i_base_filled   (i_base_filled),
      .i_offset        (i_offset),
      .i_offset_tag    (i_offset_tag),
      .i_offset_filled (i_offset_filled),
      .i_alloc         (alloc),
      .o_full          (rs_full),
      .i_cdb           (i_cdb),
      .i_cdb_valid     (i_cdb_valid),
      .o_valid         (rs_valid),
      .o_opcode        (rs_opcode),
      .o_rob_id        (rs_rob_id),
      .o_base          (rs_base),
      .o_offset        (rs_offset),
      .i_ready         (rs_ready)
   );

   ////////////////////
   // Address generation
   assign rs_addr = (rs_opcode == I_LOADB || rs_opcode == I_STOREB) ?
                    rs_base - rs_offset : rs_base + rs_offset;

   fifo #(.DEPTH_W(AQ_DEPTH_W), .WIDTH(AQ_ENTRY_W)) address_queue (
      .clk     (clk),
      .nrst    (nrst),
      .i_data  ({rs_opcode, rs_rob_id, rs_addr}),
      .i_valid (rs_valid),
      .o_ready (rs_ready),
      .o_data  ({aq_opcode, aq_rob_id, aq_addr}),
      .o_valid (aq_valid),
      .i_ready (aq_ready)
   );

   ////////////////////
   // Disambiguation
   assign aq_store    = is_store(aq_opcode);
   assign load_wait   = sb_match && !sb_match_data_ready;   // Older store, data pending
   assign lq_in_valid = aq_valid && !aq_store && !load_wait;
   assign aq_ready    = aq_store || (lq_in_ready && !load_wait);

   store_buffer sb_inst (
      .clk                 (clk),
      .nrst                (nrst),
      .i_push              (alloc && is_store(i_opcode)),
      .i_rob_id            (i_rob_id),
      .i_data              (i_data),
      .i_data_tag          (i_data_tag),
      .i_data_filled       (i_data_filled),
      .o_full              (sb_full),
      .i_cdb               (i_cdb),
      .i_cdb_valid         (i_cdb_valid),
      .i_addr_valid        (aq_valid && aq_store),
      .i_addr_rob_id       (aq_rob_id),
      .i_addr              (aq_addr),
      .i_commit_valid      (i_commit_valid),
      .i_commit_id         (i_commit_id),
      .i_commit_invalidate (i_commit_invalidate),
      .i_lookup_addr       (aq_addr),
      .o_match             (sb_match),
      .o_match_data_ready  (sb_match_data_ready),
      .o_match_data        (sb_match_data),
      .o_head_valid        (sb_head_valid),
      .o_head_write        (sb_head_write),
      .o_head_addr         (sb_head_addr),
      .o_head_data         (sb_head_data),
      .i_pop               (sb_pop)
   );

   fifo #(.DEPTH_W(LQ_DEPTH_W), .WIDTH(LQ_ENTRY_W)) load_queue (
      .clk     (clk),
      .nrst    (nrst),
      .i_data  ({aq_rob_id, aq_addr, sb_match, sb_match_data}),
      .i_valid (lq_in_valid),
      .o_ready (lq_in_ready),
      .o_data  ({lq_rob_id, lq_addr, lq_fwd, lq_data}),
      .o_valid (lq_valid),
      .i_ready (lq_ready)
   );

   ////////////////////
   // Result and memory request
   assign o_fwd_valid = lq_valid && lq_fwd;
   assign o_fwd_cdb   = {lq_rob_id, lq_data};
   assign lq_read     = lq_valid && !lq_fwd;
   assign lq_ready    = lq_fwd ? i_fwd_ready : i_mem_ready;

   // Load read beats store write
   assign store_req    = sb_head_valid && sb_head_write;
   assign o_mem_valid  = lq_read || store_req;
   assign o_mem_write  = !lq_read;
   assign o_mem_addr   = lq_read ? lq_addr : sb_head_addr;
   assign o_mem_data   = sb_head_data;
   assign o_mem_rob_id = lq_rob_id;
   assign sb_pop       = store_req && !lq_read && i_mem_ready;

endmodule

/* data_memory.sv */
`timescale 1ns/1ps

module data_memory (
   input  logic              clk,
   input  logic              nrst,
   input  logic              i_valid,
   input  logic              i_write,
   input  fcpu_pkg::data_t   i_addr,
   input  fcpu_pkg::data_t   i_data,
   input  fcpu_pkg::rob_id_t i_rob_id,
   output logic              o_ready,
   output fcpu_pkg::cdb_t    o_cdb,
   output logic              o_cdb_valid,
   input  logic              i_cdb_ready
);
   import fcpu_pkg::*;

   data_t                 mem [DMEM_WORDS];
   logic [DMEM_IDX_W-1:0] idx;
   logic                  accept;

   assign idx     = i_addr[DMEM_IDX_W-1:0];   // Low bits only
   assign o_ready = !o_cdb_valid || i_cdb_ready;
   assign accept  = i_valid && o_ready;

   always_ff @(posedge clk) begin
      if (nrst) begin
         for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] <= '0;
         end
         o_cdb_valid <= 1'b0;
      end else begin
         if (accept && i_write) begin
            mem[idx] <= i_data;
         end
         if (accept && !i_write) begin
            o_cdb_valid <= 1'b1;
         end else if (i_cdb_ready) begin
            o_cdb_valid <= 1'b0;
         end
      end
   end

   // Load response held until taken
   always_ff @(posedge clk) begin
      if (accept && !i_write) begin
         o_cdb <= {i_rob_id, mem[idx]};
      end
   end

endmodule

/* cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter (
   input  fcpu_pkg::cdb_t i_mem_cdb,
   input  logic           i_mem_valid,
   output logic           o_mem_ready,
   input  fcpu_pkg::cdb_t i_fwd_cdb,
   input  logic           i_fwd_valid,
   output logic           o_fwd_ready,
   output fcpu_pkg::cdb_t o_cdb,
   output logic           o_cdb_valid,
   input  logic           i_cdb_ready
);

   // Memory response first
   assign o_cdb_valid = i_mem_valid || i_fwd_valid;
   assign o_cdb       = i_mem_valid ? i_mem_cdb : i_fwd_cdb;
   assign o_mem_ready = i_cdb_ready;
   assign o_fwd_ready = i_cdb_ready && !i_mem_valid;

endmodule

/* mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem (
   input  logic              clk,
   input  logic              nrst,
   input  logic              i_valid,
   output logic              o_ready,
   input  fcpu_pkg::opcode_t i_opcode,
   input  fcpu_pkg::rob_id_t i_rob_id,
   input  fcpu_pkg::data_t   i_base,
   input  fcpu_pkg::rob_id_t i_base_tag,
   input  logic              i_base_filled,
   input  fcpu_pkg::data_t   i_offset,
   input  fcpu_pkg::rob_id_t i_offset_tag,
   input  logic              i_offset_filled,
   input  fcpu_pkg::data_t   i_data,
   input  fcpu_pkg::rob_id_t i_data_tag,
   input  logic              i_data_filled,
   input  fcpu_pkg::cdb_t    i_cdb,
   input  logic              i_cdb_valid,
   input  logic              i_commit_valid,
   input  fcpu_pkg::rob_id_t i_commit_id,
   input  logic              i_commit_invalidate,
   output fcpu_pkg::cdb_t    o_cdb,
   output logic              o_cdb_valid,
   input  logic              i_cdb_ready
);
   import fcpu_pkg::*;

   logic    fwd_valid;
   logic    fwd_ready;
   cdb_t    fwd_cdb;
   logic    mem_valid;
   logic    mem_write;
   data_t   mem_addr;
   data_t   mem_data;
   rob_id_t mem_rob_id;
   logic    mem_ready;
   cdb_t    resp_cdb;
   logic    resp_valid;
   logic    resp_ready;

   memory_functional_unit mfu_inst (
      .clk                 (clk),
      .nrst                (nrst),
      .i_valid             (i_valid),
      .o_ready             (o_ready),
      .i_opcode            (i_opcode),
      .i_rob_id            (i_rob_id),
      .i_base              (i_base),
      .i_base_tag          (i_base_tag),
      .i_base_filled       (i_base_filled),
      .i_offset            (i_offset),
      .i_offset_tag        (i_offset_tag),
      .i_offset_filled     (i_offset_filled),
      .i_data              (i_data),
      .i_data_tag          (i_data_tag),
      .i_data_filled       (i_data_filled),
      .i_cdb               (i_cdb),
      .i_cdb_valid         (i_cdb_valid),
      .i_commit_valid      (i_commit_valid),
      .i_commit_id         (i_commit_id),
      .i_commit_invalidate (i_commit_invalidate),
      .o_fwd_valid         (fwd_valid),
      .o_fwd_cdb           (fwd_cdb),
      .i_fwd_ready         (fwd_ready),
      .o_mem_valid         (mem_valid),
      .o_mem_write         (mem_write),
      .o_mem_addr          (mem_addr),
      .o_mem_data          (mem_data),
      .o_mem_rob_id        (mem_rob_id),
      .i_mem_ready         (mem_ready)
   );

   data_memory dmem_inst (
      .clk         (clk),
      .nrst        (nrst),
      .i_valid     (mem_valid),
      .i_write     (mem_write),
      .i_addr      (mem_addr),
      .i_data      (mem_data),
      .i_rob_id    (mem_rob_id),
      .o_ready     (mem_ready),
      .o_cdb       (resp_cdb),
      .o_cdb_valid (resp_valid),
      .i_cdb_ready (resp_ready)
   );

   cdb_arbiter arb_inst (
      .i_mem_cdb   (resp_cdb),
      .i_mem_valid (resp_valid),
      .o_mem_ready (resp_ready),
      .i_fwd_cdb   (fwd_cdb),
      .i_fwd_valid (fwd_valid),
      .o_fwd_ready (fwd_ready),
      .o_cdb       (o_cdb),
      .o_cdb_valid (o_cdb_valid),
      .i_cdb_ready (i_cdb_ready)
   );

endmodule

/* mem_subsystem_properties.sv */
`timescale 1ns/1ps

module mem_subsystem_properties (
   input logic           clk,
   input logic           nrst,
   input fcpu_pkg::cdb_t o_cdb,
   input logic           o_cdb_valid,
   input logic           i_cdb_ready
);

   ////////////////////
   // Result port
   assert property (@(posedge clk) nrst |=> !o_cdb_valid)
      else $error("o_cdb_valid high in the cycle after reset");

   // Held while the consumer stalls
   assert property (@(posedge clk) disable iff (nrst)
                    (o_cdb_valid && !i_cdb_ready) |=> (o_cdb_valid && $stable(o_cdb)))
      else $error("o_cdb changed or dropped while stalled");

   assert property (@(posedge clk) disable iff (nrst) !$isunknown(o_cdb_valid))
      else $error("o_cdb_valid is unknown");

endmodule

bind mem_subsystem mem_subsystem_properties props_inst (
   .clk         (clk),
   .nrst        (nrst),
   .o_cdb       (o_cdb),
   .o_cdb_valid (o_cdb_valid),
   .i_cdb_ready (i_cdb_ready)
);

/* mem_subsystem_tb.sv */
`timescale 1ns/1ps

module mem_subsystem_tb;
   import fcpu_pkg::*;

   localparam int NROWS      = 14;
   localparam int MAX_CYCLES = 40 * NROWS + 200;
   localparam int HALF       = 20;

   typedef struct {
      string      name;
      opcode_t    op;
      rob_id_t    id;
      data_t      base;
      data_t      offset;
      data_t      data;
      logic [2:0] late;   // {data, offset, base} sent on i_cdb
      rob_id_t    ltag;   // base tag, offset ltag+1, data ltag+2
      int         ldly;
      int         cdly;   // Commit delay after dispatch
      logic       inv;
      data_t      exp;
   } row_t;

   logic    clk;
   logic    nrst;
   logic    i_valid;
   logic    o_ready;
   opcode_t i_opcode;
   rob_id_t i_rob_id;
   data_t   i_base;
   rob_id_t i_base_tag;
   logic    i_base_filled;
   data_t   i_offset;
   rob_id_t i_offset_tag;
   logic    i_offset_filled;
   data_t   i_data;
   rob_id_t i_data_tag;
   logic    i_data_filled;
   cdb_t    i_cdb;
   logic    i_cdb_valid;
   logic    i_commit_valid;
   rob_id_t i_commit_id;
   logic    i_commit_invalidate;
   cdb_t    o_cdb;
   logic    o_cdb_valid;
   logic    i_cdb_ready;

   row_t  tbl       [NROWS];
   data_t model_exp [NROWS];
   int    sent_cyc  [NROWS];
   logic  got       [NROWS];
   logic  done_cmt  [NROWS];
   int    tag_row   [16];
   int    bc_due    [$];
   cdb_t  bc_word   [$];
   int    cyc;
   int    next_row;
   int    commit_ptr;
   int    inv_block;    // Dispatch held until the invalidated store retires
   int    loads_left;
   int    stall_left;
   int    extra;

   mem_subsystem mem_subsystem_inst (.*);

   initial begin
      clk = 1'b0;
      forever #HALF clk = ~clk;
   end

   initial begin
      repeat (MAX_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles with loads or commits outstanding", MAX_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "Simulation hung");
   end

   function automatic logic writes_mem(opcode_t op);
      return (op == I_STORE) || (op == I_STOREB);
   endfunction

   function automatic data_t operand_value(row_t row, int j);
      case (j)
         0:       return row.base;
         1:       return row.offset;
         default: return row.data;
      endcase
   endfunction

   ////////////////////
   // Stimulus table
   task automatic load_table();
      //          name            op        id    base    offset  data      late    ltag dly cdly
      tbl[0]  = '{"st_commit",    I_STORE,  4'd0, 16'd10, 16'd2, 16'h1111, 3'b000, 4'd0, 0, 2,
                  1'b0, 16'h0};
      tbl[1]  = '{"ld_same",      I_LOAD,   4'd1, 16'd12, 16'd0, 16'h0, 3'b000, 4'd0, 0, 0,
                  1'b0, 16'h1111};
      tbl[2]  = '{"stb_late",     I_STOREB, 4'd2, 16'd30, 16'd5, 16'h2222, 3'b111, 4'd4, 3, 6,
                  1'b0, 16'h0};
      tbl[3]  = '{"ldb_fwd",      I_LOADB,  4'd3, 16'd27, 16'd2, 16'h0, 3'b000, 4'd0, 0, 0,
                  1'b0, 16'h2222};
      tbl[4]  = '{"st_old",       I_STORE,  4'd4, 16'd40, 16'd0, 16'h3333, 3'b000, 4'd0, 0, 20,
                  1'b0, 16'h0};
      tbl[5]  = '{"st_young",     I_STORE,  4'd5, 16'd38, 16'd2, 16'h4444, 3'b100, 4'd8, 4, 20,
                  1'b0, 16'h0};
      tbl[6]  = '{"ld_youngest",  I_LOAD,   4'd6, 16'd36, 16'd4, 16'h0, 3'b000, 4'd0, 0, 0,
                  1'b0, 16'h4444};
      tbl[7]  = '{"st_inv",       I_STORE,  4'd7, 16'd12, 16'd0, 16'h5555, 3'b000, 4'd0, 0, 3,
                  1'b1, 16'h0};
      tbl[8]  = '{"ld_after_inv", I_LOAD,   4'd8, 16'd6, 16'd6, 16'h0, 3'b000, 4'd0, 0, 0,
                  1'b0, 16'h1111};
      tbl[9]  = '{"stb_inv",      I_STOREB, 4'd9, 16'd50, 16'd1, 16'h6666, 3'b000, 4'd0, 0, 1,
                  1'b1, 16'h0};
      tbl[10] = '{"ldb_zero",     I_LOADB,  4'd10, 16'd52, 16'd3, 16'h0, 3'b000, 4'd0, 0, 0,
                  1'b0, 16'h0};
      tbl[11] = '{"ld_late_base", I_LOAD,   4'd11, 16'd20, 16'd5, 16'h0, 3'b001, 4'd11, 5, 0,
                  1'b0, 16'h2222};
      tbl[12] = '{"ldb_late_off", I_LOADB,  4'd12, 16'd45, 16'd5, 16'h0, 3'b010, 4'd12, 2, 0,
                  1'b0, 16'h4444};
      tbl[13] = '{"ld_plain",     I_LOAD,   4'd13, 16'd0, 16'd25, 16'h0, 3'b000, 4'd0, 0, 0,
                  1'b0, 16'h2222};
   endtask

   // Program order reference memory
   task automatic build_model();
      data_t ref_mem [DMEM_WORDS];
      data_t addr;
      for (int w = 0; w < DMEM_WORDS; w++) ref_mem[w] = '0;
      for (int r = 0; r < NROWS; r++) begin
         if (tbl[r].op == I_LOADB || tbl[r].op == I_STOREB) addr = tbl[r].base - tbl[r].offset;
         else addr = tbl[r].base + tbl[r].offset;
         model_exp[r] = '0;
         if (writes_mem(tbl[r].op)) begin
            if (!tbl[r].inv) ref_mem[addr[DMEM_IDX_W-1:0]] = tbl[r].data;
         end else begin
            model_exp[r] = ref_mem[addr[DMEM_IDX_W-1:0]];
            assert (model_exp[r] == tbl[r].exp) else begin
               $display("Row %s lists %h but the reference memory gives %h",
                        tbl[r].name, tbl[r].exp, model_exp[r]);
               $display("=== FAIL ===");
               $fatal(1, "Stimulus table does not match reference model");
            end
         end
      end
   endtask

   task automatic drive_cycle();
      row_t row;
      logic found;
      while (commit_ptr < NROWS && (got[commit_ptr] || done_cmt[commit_ptr])) commit_ptr++;
      i_valid = 1'b0;
      if (next_row < NROWS && inv_block < 0) begin
         row             = tbl[next_row];
         i_valid         = 1'b1;
         i_opcode        = row.op;
         i_rob_id        = row.id;
         i_base          = row.late[0] ? 16'hbad0 : row.base;   // Stale until broadcast
         i_base_tag      = row.ltag;
         i_base_filled   = !row.late[0];
         i_offset        = row.late[1] ? 16'hbad1 : row.offset;
         i_offset_tag    = row.ltag + 4'd1;
         i_offset_filled = !row.late[1];
         i_data          = row.late[2] ? 16'hbad2 : row.data;
         i_data_tag      = row.ltag + 4'd2;
         i_data_filled   = !row.late[2];
      end
      // One broadcast per cycle
      found       = 1'b0;
      i_cdb_valid = 1'b0;
      for (int k = 0; k < bc_due.size(); k++) begin
         if (!found && bc_due[k] <= cyc) begin
            found       = 1'b1;
            i_cdb       = bc_word[k];
            i_cdb_valid = 1'b1;
            bc_due.delete(k);
            bc_word.delete(k);
         end
      end
      // In order commit once every older load has its result
      i_commit_valid = 1'b0;
      if (commit_ptr < NROWS && writes_mem(tbl[commit_ptr].op) && sent_cyc[commit_ptr] >= 0 &&
          cyc >= sent_cyc[commit_ptr] + tbl[commit_ptr].cdly) begin
         i_commit_valid       = 1'b1;
         i_commit_id          = tbl[commit_ptr].id;
         i_commit_invalidate  = tbl[commit_ptr].inv;
         done_cmt[commit_ptr] = 1'b1;
         if (inv_block == commit_ptr) inv_block = -1;
      end
      if (stall_left > 0) begin
         i_cdb_ready = 1'b0;
         stall_left--;
      end else begin
         i_cdb_ready = 1'b1;
         if ($urandom_range(3) == 0) stall_left = $urandom_range(4, 1);
      end
   endtask

   task automatic sample_cycle();
      int      r;
      rob_id_t tag;
      data_t   val;
      if (i_valid && o_ready) begin
         sent_cyc[next_row] = cyc;
         for (int j = 0; j < 3; j++) begin
            if (tbl[next_row].late[j]) begin
               bc_due.push_back(cyc + tbl[next_row].ldly + j);
               bc_word.push_back({tbl[next_row].ltag + rob_id_t'(j),
                                  operand_value(tbl[next_row], j)});
            end
         end
         if (tbl[next_row].inv) inv_block = next_row;
         next_row++;
      end
      if (o_cdb_valid && i_cdb_ready) begin
         tag = o_cdb[DATA_W +: RSV_ID_W];
         val = o_cdb[DATA_W-1:0];
         r   = tag_row[tag];
         assert (r >= 0 && sent_cyc[r] >= 0 && !writes_mem(tbl[r].op)) else begin
            $display("Result with tag %0d belongs to no dispatched load", tag);
            $display("=== FAIL ===");
            $fatal(1, "Unexpected result tag");
         end
         assert (!got[r]) else begin
            $display("Load %s returned a second result", tbl[r].name);
            $display("=== FAIL ===");
            $fatal(1, "Duplicate result");
         end
         assert (val == model_exp[r]) else begin
            $display("[FAIL] %s: expected %h, actual %h", tbl[r].name, model_exp[r], val);
            $display("=== FAIL ===");
            $fatal(1, "Wrong load value");
         end
         got[r] = 1'b1;
         loads_left--;
      end
   endtask

   ////////////////////
   // Main sequence
   initial begin
      void'($urandom(32'h5e73_e2e0));
      nrst                = 1'b1;
      i_valid             = 1'b0;
      i_opcode            = '0;
      i_rob_id            = '0;
      i_base              = '0;
      i_base_tag          = '0;
      i_base_filled       = 1'b0;
      i_offset            = '0;
      i_offset_tag        = '0;
      i_offset_filled     = 1'b0;
      i_data              = '0;
      i_data_tag          = '0;
      i_data_filled       = 1'b0;
      i_cdb               = '0;
      i_cdb_valid         = 1'b0;
      i_commit_valid      = 1'b0;
      i_commit_id         = '0;
      i_commit_invalidate = 1'b0;
      i_cdb_ready         = 1'b1;
      load_table();
      build_model();
      loads_left = 0;
      for (int t = 0; t < 16; t++) tag_row[t] = -1;
      for (int r = 0; r < NROWS; r++) begin
         sent_cyc[r]         = -1;
         got[r]              = 1'b0;
         done_cmt[r]         = 1'b0;
         tag_row[tbl[r].id] = r;
         if (!writes_mem(tbl[r].op)) loads_left++;
      end
      cyc        = 0;
      next_row   = 0;
      commit_ptr = 0;
      inv_block  = -1;
      stall_left = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      nrst = 1'b0;
      while (loads_left > 0 || commit_ptr < NROWS) begin
         @(negedge clk);
         drive_cycle();
         #(HALF / 2);
         sample_cycle();
         cyc++;
      end
      // Quiet tail where nothing more may come out
      extra = 0;
      repeat (20) begin
         @(negedge clk);
         i_valid        = 1'b0;
         i_cdb_valid    = 1'b0;
         i_commit_valid = 1'b0;
         i_cdb_ready    = 1'b1;
         #(HALF / 2);
         if (o_cdb_valid) extra++;
      end
      if (extra == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         $display("%0d results appeared after every load had completed", extra);
         $display("=== FAIL ===");
         $fatal(1, "Extra results");
      end
   end

endmodule

/* files.f */
fcpu_pkg.sv
fifo.sv
reservation_station.sv
store_buffer.sv
memory_functional_unit.sv
data_memory.sv
cdb_arbiter.sv
mem_subsystem.sv
mem_subsystem_properties.sv
mem_subsystem_tb.sv

/* Makefile */
TOP  := mem_subsystem_tb
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir
